//--- hw/cmac_mul_cfg_pkg.sv
package cmac_mul_cfg_pkg;

  // ==============================
  // lane and word geometry
  // ==============================

  // int8 mode splits the slice in two
  localparam int unsigned lane_num = 2;
  localparam int unsigned lane_w   = 16;   // one result half
  localparam int unsigned res_w    = 32;   // full redundant word

  // per-lane valid, bit k gates result half k
  typedef logic [lane_num-1:0] lane_vld_t;

  // ==============================
  // sign-extension bias
  // ==============================

  // each booth pp carries +1 at bit 16 of its own weight
  // weights 4^0..4^7 -> 0x5555 above bit 16
  localparam logic [res_w-1:0] bias_int16 = 32'h5555_0000;

  // int8: four 9-bit pps per lane, +1 at bit 8 each
  localparam logic [res_w-1:0] bias_int8  = 32'h5500_5500;

  // bias the pair shows for a zero product in a given mode
  function automatic logic [res_w-1:0] mode_bias(input logic is_int8);
    return is_int8 ? bias_int8 : bias_int16;
  endfunction

  // one half of the mode bias, lane 0 is the low half
  function automatic logic [lane_w-1:0] lane_bias(
    input logic        is_int8,
    input int unsigned lane
  );
    logic [res_w-1:0] full;
    full = mode_bias(is_int8);
    return full[lane*lane_w +: lane_w];
  endfunction

endpackage

//--- hw/cmac_mul_pp_pkg.sv
package cmac_mul_pp_pkg;

  // ==============================
  // operand side
  // ==============================

  localparam int unsigned op_w      = 16;  // operand width
  localparam int unsigned booth_num = 8;   // radix-4 digits per operand
  localparam int unsigned pp_w      = 17;  // selector output, sign bit inverted
  localparam int unsigned l1_w      = 24;  // level-1 tree width

  // one operand as it enters the slice
  typedef struct packed {
    logic [op_w-1:0]                    dat;
    logic [cmac_mul_cfg_pkg::lane_num-1:0] nz;   // per-lane non-zero
    logic                               pvld;
  } cmac_op_t;

  // ==============================
  // booth recoding
  // ==============================

  // overlapping triplet {b[2i+1], b[2i], b[2i-1]}
  typedef logic [2:0] booth_code_t;

  typedef booth_code_t [booth_num-1:0] booth_code_vec_t;

  // one partial product from a selector
  typedef struct packed {
    logic [pp_w-1:0] data;
    logic            inv;   // +1 for negation, lands on the next pp slot
  } booth_sel_t;

  typedef booth_sel_t [booth_num-1:0] booth_sel_vec_t;

  // ==============================
  // result
  // ==============================

  // a + b = product + mode bias
  typedef struct packed {
    logic [cmac_mul_cfg_pkg::res_w-1:0] a;
    logic [cmac_mul_cfg_pkg::res_w-1:0] b;
  } cmac_res_t;

endpackage

//--- hw/cmac_mul_ctrl.sv
`timescale 1ns/1ns

module cmac_mul_ctrl (
  input  logic                              nvdla_core_clk,
  input  logic                              nvdla_core_rstn,
  input  logic                              cfg_reg_en,
  input  logic                              cfg_is_int8,
  input  cmac_mul_pp_pkg::cmac_op_t         op_a,      // multiplier, gets recoded
  input  cmac_mul_pp_pkg::cmac_op_t         op_b,      // multiplicand
  output logic                              is_int8,
  output cmac_mul_cfg_pkg::lane_vld_t       lane_vld,
  output cmac_mul_pp_pkg::booth_code_vec_t  codes,
  output logic [cmac_mul_pp_pkg::op_w-1:0]  src_lo,
  output logic [cmac_mul_pp_pkg::op_w-1:0]  src_hi
);

  localparam int unsigned half_w   = cmac_mul_pp_pkg::op_w / 2;      // one byte
  localparam int unsigned half_num = cmac_mul_pp_pkg::booth_num / 2; // codes per byte

  logic [half_w:0] code_lo;   // 9 bits, four overlapping triplets
  logic [half_w:0] code_hi;

  // ==============================
  // config register
  // ==============================

  // mode only moves on a strobe edge
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      is_int8 <= 1'b0;   // int16 after reset
    end else if (cfg_reg_en) begin
      is_int8 <= cfg_is_int8;
    end
  end

  // ==============================
  // lane valids
  // ==============================

  always_comb begin
    for (int k = 0; k < cmac_mul_cfg_pkg::lane_num; k++) begin
      // both sides valid and both bytes non-zero
      lane_vld[k] = op_a.pvld & op_b.pvld & op_a.nz[k] & op_b.nz[k];
    end
  end

  // ==============================
  // booth code extraction
  // ==============================

  assign code_lo = {op_a.dat[half_w-1:0], 1'b0};   // implicit b[-1] = 0

  // int8: upper byte is its own number, restart with b[-1] = 0
  // int16: continue from bit 7
  assign code_hi = is_int8 ? {op_a.dat[2*half_w-1:half_w], 1'b0}
                           : op_a.dat[2*half_w-1:half_w-1];

  always_comb begin
    for (int k = 0; k < half_num; k++) begin
      codes[k]          = code_lo[2*k +: 3];
      codes[k+half_num] = code_hi[2*k +: 3];
    end
  end

  // ==============================
  // multiplicand select
  // ==============================

  // int8 lanes see a zero-extended byte, the selector picks the sign at bit 7
  assign src_lo = is_int8 ? {{half_w{1'b0}}, op_b.dat[half_w-1:0]} : op_b.dat;
  assign src_hi = is_int8 ? {{half_w{1'b0}}, op_b.dat[2*half_w-1:half_w]} : op_b.dat;

endmodule

//--- hw/cmac_booth_sel.sv
`timescale 1ns/1ns

module cmac_booth_sel (
  input  cmac_mul_pp_pkg::booth_code_t      code,
  input  logic                              is_int8,
  input  logic [cmac_mul_pp_pkg::op_w-1:0]  src,
  output cmac_mul_pp_pkg::booth_sel_t       sel
);

  localparam int unsigned pp_w   = cmac_mul_pp_pkg::pp_w;
  localparam int unsigned byte_w = cmac_mul_pp_pkg::op_w / 2;

  logic                pick_one;   // +/- 1x
  logic                pick_two;   // +/- 2x
  logic                neg;        // negative digit
  logic [pp_w-1:0]     mag16;      // signed multiple, 17 bits
  logic [byte_w:0]     mag8;       // signed multiple, 9 bits
  logic [pp_w-1:0]     enc16;
  logic [byte_w:0]     enc8;

  // ==============================
  // digit decode
  // ==============================

  // 000 / 111 -> 0, 001 / 010 -> +1, 011 -> +2
  // 100 -> -2, 101 / 110 -> -1
  assign pick_one = code[1] ^ code[0];
  assign pick_two = (code == 3'b011) | (code == 3'b100);
  assign neg      = code[2] & ~(code[1] & code[0]);   // 111 is zero, no negate

  // ==============================
  // multiple select
  // ==============================

  always_comb begin
    mag16 = '0;
    mag8  = '0;
    if (pick_one) begin
      mag16 = {src[pp_w-2], src};                  // sign extend by one
      mag8  = {src[byte_w-1], src[byte_w-1:0]};
    end else if (pick_two) begin
      mag16 = {src, 1'b0};                         // 2x, sign now at top
      mag8  = {src[byte_w-1:0], 1'b0};
    end
  end

  // ==============================
  // negate and sign encode
  // ==============================

  always_comb begin
    // ones complement here, the +1 rides on inv
    enc16 = neg ? ~mag16 : mag16;
    enc8  = neg ? ~mag8 : mag8;
    // flip sign bit -> value + 2^n, no sign extension needed in the tree
    enc16[pp_w-1] = ~enc16[pp_w-1];
    enc8[byte_w]  = ~enc8[byte_w];
  end

  assign sel.data = is_int8 ? {{(pp_w-byte_w-1){1'b0}}, enc8} : enc16;
  assign sel.inv  = neg;

endmodule

//--- hw/cmac_csa_tree.sv
`timescale 1ns/1ns

// wallace-style reduction, num_in words down to a sum/carry pair
module cmac_csa_tree #(
  parameter int unsigned num_in = 5,    // at least 2
  parameter int unsigned width  = 24
) (
  input  logic [num_in-1:0][width-1:0] addends,
  output logic [width-1:0]             sum,
  output logic [width-1:0]             carry
);

  // ==============================
  // layered 3:2 compression
  // ==============================

  always_comb begin : reduce
    logic [width-1:0] cur [num_in];
    logic [width-1:0] nxt [num_in];
    int               cnt;        // live words in cur
    int               grp;        // full triplets this layer
    int               rem;        // leftovers, passed straight down

    for (int i = 0; i < num_in; i++) begin
      cur[i] = addends[i];
    end
    cnt = num_in;

    // num_in layers is more than enough, extra ones do nothing
    for (int lvl = 0; lvl < num_in; lvl++) begin
      if (cnt > 2) begin
        grp = cnt / 3;
        rem = cnt % 3;
        nxt = cur;
        for (int g = 0; g < num_in / 3; g++) begin
          if (g < grp) begin
            // full adder per bit column
            nxt[2*g]   = cur[3*g] ^ cur[3*g+1] ^ cur[3*g+2];
            nxt[2*g+1] = ((cur[3*g] & cur[3*g+1]) |
                          (cur[3*g] & cur[3*g+2]) |
                          (cur[3*g+1] & cur[3*g+2])) << 1;   // top carry drops, mod 2^width
          end
        end
        for (int r = 0; r < 2; r++) begin
          if (r < rem) begin
            nxt[2*grp+r] = cur[3*grp+r];
          end
        end
        cur = nxt;
        cnt = 2*grp + rem;
      end
    end

    sum   = cur[0];
    carry = cur[1];
  end

endmodule

//--- hw/cmac_pp_reduce.sv
`timescale 1ns/1ns

module cmac_pp_reduce #(
  parameter int unsigned l1_width = 24,   // per-lane tree
  parameter int unsigned l2_width = 32    // merge tree, full result word
) (
  input  cmac_mul_pp_pkg::booth_sel_vec_t sel,
  input  logic                            is_int8,
  input  cmac_mul_cfg_pkg::lane_vld_t     lane_vld,
  output cmac_mul_pp_pkg::cmac_res_t      res
);

  localparam int unsigned lane_num = cmac_mul_cfg_pkg::lane_num;
  localparam int unsigned lane_w   = cmac_mul_cfg_pkg::lane_w;
  localparam int unsigned grp_sel  = cmac_mul_pp_pkg::booth_num / lane_num;  // 4
  localparam int unsigned grp_in   = grp_sel + 1;     // plus the trailing inv
  localparam int unsigned grp_sft  = 2 * grp_sel;     // upper group weight, 8

  logic [lane_num-1:0][grp_in-1:0][l1_width-1:0] l1_in;
  logic [lane_num-1:0][l1_width-1:0]             l1_sum;
  logic [lane_num-1:0][l1_width-1:0]             l1_carry;
  logic [2*lane_num-1:0][l2_width-1:0]           l2_in;
  logic [l2_width-1:0]                           l2_sum;
  logic [l2_width-1:0]                           l2_carry;
  logic [l2_width-1:0]                           ori_a;
  logic [l2_width-1:0]                           ori_b;

  // ==============================
  // pp alignment
  // ==============================

  always_comb begin
    l1_in = '0;
    for (int g = 0; g < lane_num; g++) begin
      for (int k = 0; k < grp_sel; k++) begin
        l1_in[g][k] = l1_width'(sel[grp_sel*g+k].data) << (2*k);   // radix-4 weight
        if (k > 0) begin
          // previous digit's +1 sits just below this pp
          l1_in[g][k][2*k-2] = sel[grp_sel*g+k-1].inv;
        end
      end
      // last inv of the group gets its own word
      l1_in[g][grp_sel][2*grp_sel-2] = sel[grp_sel*g+grp_sel-1].inv;
    end
  end

  // ==============================
  // level 1, one tree per byte group
  // ==============================

  for (genvar g = 0; g < lane_num; g++) begin : g_l1
    cmac_csa_tree #(
      .num_in (grp_in),
      .width  (l1_width)
    ) u_tree_l1 (
      .addends (l1_in[g]),
      .sum     (l1_sum[g]),
      .carry   (l1_carry[g])
    );
  end

  // ==============================
  // level 2, int16 merge
  // ==============================

  // quiet in int8, nobody reads it
  always_comb begin
    l2_in = '0;
    if (!is_int8) begin
      l2_in[0] = l2_width'(l1_sum[0]);
      l2_in[1] = l2_width'(l1_carry[0]);
      l2_in[2] = l2_width'(l1_sum[1]) << grp_sft;     // upper digits, 4^4
      l2_in[3] = l2_width'(l1_carry[1]) << grp_sft;
    end
  end

  cmac_csa_tree #(
    .num_in (2*lane_num),
    .width  (l2_width)
  ) u_tree_l2 (
    .addends (l2_in),
    .sum     (l2_sum),
    .carry   (l2_carry)
  );

  // ==============================
  // output select and lane gating
  // ==============================

  assign ori_a = is_int8 ? {l1_sum[1][lane_w-1:0], l1_sum[0][lane_w-1:0]} : l2_sum;
  assign ori_b = is_int8 ? {l1_carry[1][lane_w-1:0], l1_carry[0][lane_w-1:0]} : l2_carry;

  always_comb begin
    for (int k = 0; k < lane_num; k++) begin
      if (lane_vld[k]) begin
        res.a[k*lane_w +: lane_w] = ori_a[k*lane_w +: lane_w];
        res.b[k*lane_w +: lane_w] = ori_b[k*lane_w +: lane_w];
      end else begin
        // idle lane looks like a zero product
        res.a[k*lane_w +: lane_w] = cmac_mul_cfg_pkg::lane_bias(is_int8, k);
        res.b[k*lane_w +: lane_w] = '0;
      end
    end
  end

endmodule

//--- hw/cmac_mac_mul.sv
`timescale 1ns/1ns

module cmac_mac_mul #(
  parameter int unsigned l1_width = cmac_mul_pp_pkg::l1_w,
  parameter int unsigned l2_width = cmac_mul_cfg_pkg::res_w
) (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  logic                        cfg_reg_en,    // mode load strobe
  input  logic                        cfg_is_int8,
  input  cmac_mul_pp_pkg::cmac_op_t   op_a,
  input  cmac_mul_pp_pkg::cmac_op_t   op_b,
  output cmac_mul_pp_pkg::cmac_res_t  res
);

  localparam int unsigned half_num = cmac_mul_pp_pkg::booth_num / 2;

  logic                              is_int8;
  cmac_mul_cfg_pkg::lane_vld_t       lane_vld;
  cmac_mul_pp_pkg::booth_code_vec_t  codes;
  logic [cmac_mul_pp_pkg::op_w-1:0]  src_lo;   // multiplicand, digits 0..3
  logic [cmac_mul_pp_pkg::op_w-1:0]  src_hi;   // multiplicand, digits 4..7
  cmac_mul_pp_pkg::booth_sel_vec_t   sel;

  // ==============================
  // config, valids, recoding
  // ==============================

  cmac_mul_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_reg_en      (cfg_reg_en),
    .cfg_is_int8     (cfg_is_int8),
    .op_a            (op_a),
    .op_b            (op_b),
    .is_int8         (is_int8),
    .lane_vld        (lane_vld),
    .codes           (codes),
    .src_lo          (src_lo),
    .src_hi          (src_hi)
  );

  // ==============================
  // booth selectors
  // ==============================

  for (genvar i = 0; i < cmac_mul_pp_pkg::booth_num; i++) begin : g_booth
    cmac_booth_sel u_booth_sel (
      .code    (codes[i]),
      .is_int8 (is_int8),
      .src     ((i < half_num) ? src_lo : src_hi),
      .sel     (sel[i])
    );
  end

  // trees and output gating
  cmac_pp_reduce #(
    .l1_width (l1_width),
    .l2_width (l2_width)
  ) u_pp_reduce (
    .sel      (sel),
    .is_int8  (is_int8),
    .lane_vld (lane_vld),
    .res      (res)
  );

endmodule

//--- tests/cmac_mac_mul_checker.sv
`timescale 1ns/1ns

module cmac_mac_mul_checker (
  input logic                        nvdla_core_clk,
  input logic                        nvdla_core_rstn,
  input logic                        cfg_reg_en,
  input logic                        is_int8,
  input cmac_mul_cfg_pkg::lane_vld_t lane_vld,
  input cmac_mul_pp_pkg::cmac_res_t  res
);

  localparam int unsigned lane_w = cmac_mul_cfg_pkg::lane_w;
  localparam logic [31:0] bias16 = cmac_mul_cfg_pkg::bias_int16;
  localparam logic [31:0] bias8  = cmac_mul_cfg_pkg::bias_int8;

  // ==============================
  // mode and lane valids
  // ==============================

  // int16 is one product over both halves
  a_int16_lanes_equal: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !is_int8 |-> (lane_vld[0] == lane_vld[1]))
    else $error("lane valids differ in int16 mode");

  a_mode_on_strobe: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (is_int8 != $past(is_int8)) |-> $past(cfg_reg_en))   // mode reg loads on strobe only
    else $error("mode changed without cfg_reg_en");

  // ==============================
  // idle lane gating
  // ==============================

  for (genvar k = 0; k < cmac_mul_cfg_pkg::lane_num; k++) begin : g_lane
    a_idle_lane: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      !lane_vld[k] |-> (res.b[k*lane_w +: lane_w] == '0) &&
        (res.a[k*lane_w +: lane_w] == (is_int8 ? bias8[k*lane_w +: lane_w]
                                                : bias16[k*lane_w +: lane_w])))
      else $error("idle lane %0d not at its bias", k);
  end

endmodule

bind cmac_mac_mul cmac_mac_mul_checker u_checker (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .cfg_reg_en      (cfg_reg_en),
  .is_int8         (is_int8),
  .lane_vld        (lane_vld),
  .res             (res)
);

//--- tests/cmac_mac_mul_tb.sv
`timescale 1ns/1ns

module cmac_mac_mul_tb;

  localparam logic [31:0] seed     = 32'hde90_a4d4;
  localparam int          vec_max  = 64;     // pattern memory depth
  localparam int          wait_max = 50;     // cycles before a wait gives up
  localparam int          rand_blk = 150;    // random vectors per mode block
  localparam string       pat_file = "tests/cmac_mul_patterns.txt";
  localparam logic [31:0] bias16   = cmac_mul_cfg_pkg::bias_int16;
  localparam logic [31:0] bias8    = cmac_mul_cfg_pkg::bias_int8;

  logic                       nvdla_core_clk;
  logic                       nvdla_core_rstn;
  logic                       cfg_reg_en;
  logic                       cfg_is_int8;
  cmac_mul_pp_pkg::cmac_op_t  op_a;
  cmac_mul_pp_pkg::cmac_op_t  op_b;
  cmac_mul_pp_pkg::cmac_res_t res;

  logic [83:0] pat_mem [vec_max];   // one vector per word
  int          err_cnt;
  int          chk_cnt;
  logic        cur_int8;            // mode the dut should be in

  cmac_mac_mul u_cmac_mac_mul (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_reg_en      (cfg_reg_en),
    .cfg_is_int8     (cfg_is_int8),
    .op_a            (op_a),
    .op_b            (op_b),
    .res             (res)
  );

  // ==============================
  // clock and reset
  // ==============================

  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;   // 10 ns
  end

  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (8) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
  end

  // ==============================
  // reference model and checks
  // ==============================

  task automatic compare_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  function automatic logic [1:0] lanes_on(input cmac_mul_pp_pkg::cmac_op_t a,
                                          input cmac_mul_pp_pkg::cmac_op_t b);
    return {2{a.pvld & b.pvld}} & a.nz & b.nz;   // both valid, both bytes non-zero
  endfunction

  // a + b the dut must show, straight from the signed product
  function automatic logic [31:0] expected_sum(input logic int8,
                                               input cmac_mul_pp_pkg::cmac_op_t a,
                                               input cmac_mul_pp_pkg::cmac_op_t b);
    logic [1:0]  on;
    logic [31:0] xa;
    logic [31:0] xb;
    logic [15:0] ya;
    logic [15:0] yb;
    logic [31:0] sum;
    on  = lanes_on(a, b);
    sum = '0;
    if (int8) begin
      for (int k = 0; k < 2; k++) begin
        ya = {{8{a.dat[8*k+7]}}, a.dat[8*k +: 8]};   // sign extend, low 16 of product is exact
        yb = {{8{b.dat[8*k+7]}}, b.dat[8*k +: 8]};
        sum[16*k +: 16] = on[k] ? ya * yb + bias8[16*k +: 16] : bias8[16*k +: 16];
      end
    end else begin
      xa  = {{16{a.dat[15]}}, a.dat};
      xb  = {{16{b.dat[15]}}, b.dat};
      sum = on[0] ? xa * xb + bias16 : bias16;
    end
    return sum;
  endfunction

  task automatic check_res(input string tag, input logic [31:0] exp);
    logic [1:0]  on;
    logic [15:0] half;
    on = lanes_on(op_a, op_b);
    if (cur_int8) begin
      for (int k = 0; k < 2; k++) begin
        half = res.a[16*k +: 16] + res.b[16*k +: 16];   // lanes wrap at 16 bits
        compare_val($sformatf("%s lane %0d sum", tag, k), {16'h0, half}, {16'h0, exp[16*k +: 16]});
      end
    end else begin
      compare_val({tag, " sum"}, res.a + res.b, exp);
    end
    for (int k = 0; k < 2; k++) begin
      if (!on[k]) begin
        compare_val($sformatf("%s idle lane %0d b", tag, k), {16'h0, res.b[16*k +: 16]}, 32'h0);
      end
    end
  endtask

  // ==============================
  // drivers
  // ==============================

  task automatic apply_ops(input cmac_mul_pp_pkg::cmac_op_t a, input cmac_mul_pp_pkg::cmac_op_t b);
    @(posedge nvdla_core_clk);
    cfg_reg_en <= 1'b0;
    op_a       <= a;
    op_b       <= b;
    @(negedge nvdla_core_clk);   // res settled mid cycle
  endtask

  task automatic load_mode(input logic int8);
    @(posedge nvdla_core_clk);
    cfg_reg_en  <= 1'b1;
    cfg_is_int8 <= int8;
    op_a.pvld   <= 1'b0;   // idle while the mode moves
    op_b.pvld   <= 1'b0;
    @(negedge nvdla_core_clk);
    // strobe cycle still runs in the old mode
    compare_val("strobe cycle a", res.a, cur_int8 ? bias8 : bias16);
    compare_val("strobe cycle b", res.b, 32'h0);
    cur_int8 = int8;
  endtask

  // flip the mode pin with no strobe, mode must hold
  task automatic wiggle_mode_pin();
    @(posedge nvdla_core_clk);
    cfg_reg_en  <= 1'b0;
    cfg_is_int8 <= ~cur_int8;
    @(negedge nvdla_core_clk);
  endtask

  task automatic replay_patterns();
    cmac_mul_pp_pkg::cmac_op_t a;
    cmac_mul_pp_pkg::cmac_op_t b;
    logic [83:0]               w;
    int                        n;
    $readmemh(pat_file, pat_mem);
    n = 0;
    while (n < vec_max && pat_mem[n][83:80] != 4'hf) begin   // f marks the end
      w = pat_mem[n];
      if (w[80] != cur_int8) load_mode(w[80]);
      a.dat  = w[79:64];
      a.nz   = w[61:60];
      a.pvld = w[56];
      b.dat  = w[55:40];
      b.nz   = w[37:36];
      b.pvld = w[32];
      apply_ops(a, b);
      check_res($sformatf("pattern %0d", n), w[31:0]);
      n++;
    end
    if (n == 0 || n == vec_max) begin
      err_cnt++;
      $display("pattern file read %0d vectors and no end marker before the last one", n);
    end
  endtask

  task automatic run_random(input int num);
    cmac_mul_pp_pkg::cmac_op_t a;
    cmac_mul_pp_pkg::cmac_op_t b;
    for (int i = 0; i < num; i++) begin
      a.dat  = 16'($urandom);
      b.dat  = 16'($urandom);
      if ($urandom % 8 == 0) a.dat = 16'h8000;   // most negative operand
      if ($urandom % 8 == 0) b.dat = 16'h8080;
      a.pvld = ($urandom % 8) != 0;
      b.pvld = ($urandom % 8) != 0;
      if (cur_int8) begin
        a.nz = {($urandom % 4) != 0, ($urandom % 4) != 0};   // lanes drop out on their own
        b.nz = {($urandom % 4) != 0, ($urandom % 4) != 0};
      end else begin
        a.nz = {2{($urandom % 8) != 0}};   // int16 keeps both flags equal
        b.nz = {2{($urandom % 8) != 0}};
      end
      apply_ops(a, b);
      check_res($sformatf("random %0d", i), expected_sum(cur_int8, a, b));
    end
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin : main
    int cnt;
    cfg_reg_en  = 1'b0;
    cfg_is_int8 = 1'b0;
    op_a        = '0;
    op_b        = '0;
    err_cnt     = 0;
    chk_cnt     = 0;
    cur_int8    = 1'b0;
    void'($urandom(seed));
    cnt = 0;
    while (nvdla_core_rstn !== 1'b1 && cnt < wait_max) begin
      @(negedge nvdla_core_clk);
      cnt++;
    end
    if (nvdla_core_rstn !== 1'b1) begin
      $display("timeout: reset still asserted after %0d cycles", wait_max);
      $display("ERRORS FOUND");
      $finish;
    end else begin
      compare_val("reset a", res.a, bias16);   // idle int16 slice
      compare_val("reset b", res.b, 32'h0);
      replay_patterns();
      wiggle_mode_pin();
      run_random(20);
      for (int blk = 0; blk < 4; blk++) begin
        load_mode(~blk[0]);   // int8, int16, int8, int16
        run_random(rand_blk);
      end
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule

//--- tests/cmac_mul_patterns.txt
// mode_adat_anz_apvld_bdat_bnz_bpvld_exphi_explo; mode 0 int16, 1 int8, f ends the list
// int8: each half of a+b per lane; int16: 32-bit a+b split as hi and lo
0_0003_3_1_0005_3_1_5555_000f
0_8000_3_1_8000_3_1_9555_0000
0_0000_3_1_1234_3_1_5555_0000
0_0002_3_1_0100_3_1_5555_0200
0_ffff_3_1_7fff_3_1_5554_8001
0_7fff_3_1_8000_3_1_1555_8000
0_0006_3_1_fffd_3_1_5554_ffee
0_1234_3_1_5678_3_1_5b7b_0060
0_1111_3_0_2222_3_1_5555_0000
0_1111_3_1_2222_0_1_5555_0000
0_fffe_3_1_8000_3_1_5556_0000
1_0302_3_1_0504_3_1_550f_5508
1_8080_3_1_8080_3_1_9500_9500
1_7f80_3_1_807f_3_1_1580_1580
1_ff01_3_1_02ff_3_1_54fe_54ff
1_0600_3_1_fd00_3_1_54ee_5500
1_0302_2_1_0504_3_1_550f_5500
1_0302_3_1_0504_1_1_5500_5508
1_0302_3_0_0504_3_1_5500_5500
1_1234_3_1_5678_3_1_5b0c_6d60
1_81c3_3_1_7e3d_3_1_167e_4677
0_ff00_3_1_0100_3_1_5554_0000
f_0000_0_0_0000_0_0_0000_0000

//--- files.f
hw/cmac_mul_cfg_pkg.sv
hw/cmac_mul_pp_pkg.sv
hw/cmac_mul_ctrl.sv
hw/cmac_booth_sel.sv
hw/cmac_csa_tree.sv
hw/cmac_pp_reduce.sv
hw/cmac_mac_mul.sv
tests/cmac_mac_mul_checker.sv
tests/cmac_mac_mul_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cmac_mac_mul testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module cmac_mac_mul_tb -o sim_cmac_mac_mul
./obj_dir/sim_cmac_mac_mul > sim.log 2>&1
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
